/* Makefile */
# Verilator build and run of the PC monitor testbench

VERILATOR ?= verilator
TOP       ?= tbPcMonitor
FILELIST  ?= pcMonitor.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail if the log reports a failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Simulation log in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/pcMonitorConsts.svh */
/*
  Constants for the PC monitor
  PC width, compared bits, stuck limit and sleep delay
*/
`ifndef PC_MONITOR_CONSTS_SVH
`define PC_MONITOR_CONSTS_SVH

// Full program counter width
`define PC_WIDTH 64

// Low PC bits compared against the targets
`define MATCH_BITS 30

// Consecutive same-PC retires that count as stuck
`define STUCK_LIMIT 500

// Cycles from the latched verdict to the core hold
`define SLEEP_DELAY 20

`endif

/* common/tracePkg.sv */
/*
  Trace types for the PC monitor
  Program counter, compared slice and stuck counter
*/
`include "pcMonitorConsts.svh"

package tracePkg;

  // Retired program counter
  typedef logic [`PC_WIDTH-1:0] pcT;

  // Part of a PC that is checked against the targets
  typedef logic [`MATCH_BITS-1:0] matchPcT;

  // Repeat counter, 10 bits covers the stuck limit
  typedef logic [9:0] stuckCountT;

  // Low compare bits of a full PC
  function automatic matchPcT lowBits(input pcT pc);
    return pc[`MATCH_BITS-1:0];
  endfunction

endpackage

/* common/verdictPkg.sv */
/*
  Verdict types for the PC monitor
  Test outcome and the sleep timer
*/
`include "pcMonitorConsts.svh"

package verdictPkg;

  // Bit 0 is pass and bit 1 is fail
  typedef enum logic [1:0] {
    verdictNone = 2'b00,
    verdictPass = 2'b01,
    verdictFail = 2'b10
  } verdictT;

  // Sleep timer, 5 bits covers the sleep delay
  typedef logic [4:0] sleepCountT;

  // Last count before the hold is raised
  localparam sleepCountT sleepLast = sleepCountT'(`SLEEP_DELAY - 1);

endpackage

/* hw/pcMonitor/addressMatch.sv */
/*
  Address match, second stage of the PC monitor
  Compares the captured PC against five targets, registers pass and fail hits
*/
`timescale 1ns/10ps
`include "pcMonitorConsts.svh"

module addressMatch (
  input  logic         clk,
  input  logic         pcFail,       // Async reset
  input  logic         capValid,
  input  tracePkg::pcT capPc,
  input  logic         stuckIn,
  input  tracePkg::pcT passPc,
  input  tracePkg::pcT failPc,
  input  tracePkg::pcT finishPc,
  input  tracePkg::pcT toHostPc,
  input  tracePkg::pcT failAltPc,
  input  logic         checkToHost,  // Enables the to-host target
  output logic         passHit,
  output logic         failHit
);
  import tracePkg::*;

  matchPcT capLow;
  matchPcT passLow;
  matchPcT failLow;
  matchPcT finishLow;
  matchPcT toHostLow;
  matchPcT failAltLow;
  logic    passNext;
  logic    failNext;

  // Only the low bits take part in the compare
  assign capLow     = lowBits(capPc);
  assign passLow    = lowBits(passPc);
  assign failLow    = lowBits(failPc);
  assign finishLow  = lowBits(finishPc);
  assign toHostLow  = lowBits(toHostPc);
  assign failAltLow = lowBits(failAltPc);

  // ----------------------------------------
  // Target compare
  // ----------------------------------------
  // A zero finish, to-host or alt-fail target is disabled
  assign passNext = capValid && (
    (capLow == passLow) ||
    ((capLow == finishLow) && (finishLow != '0)) ||
    ((capLow == toHostLow) && (toHostLow != '0) && checkToHost));

  assign failNext = stuckIn || (capValid && (
    (capLow == failLow) ||
    ((capLow == failAltLow) && (failAltLow != '0))));

  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      passHit <= 1'b0;
      failHit <= 1'b0;
    end else begin
      passHit <= passNext;
      failHit <= failNext;   // Includes the stuck flag
    end
  end

endmodule

/* hw/pcMonitor/pcMonitor.sv */
/*
  PC monitor top level
  Capture, address match and verdict stages for one core's retire trace
*/
`timescale 1ns/10ps
`include "pcMonitorConsts.svh"

module pcMonitor (
  input  logic         clk,
  input  logic         pcFail,        // Async reset
  input  logic         retire,
  input  tracePkg::pcT retirePc,
  input  tracePkg::pcT passPc,
  input  tracePkg::pcT failPc,
  input  tracePkg::pcT finishPc,
  input  tracePkg::pcT toHostPc,
  input  tracePkg::pcT failAltPc,
  input  logic         checkToHost,
  input  logic         setFail,
  input  logic         disableStuck,
  output logic         passed,
  output logic         failed,
  output logic         stuck,
  output logic         coreHold
);
  import tracePkg::*;
  import verdictPkg::*;

  logic    capValid;
  pcT      capPc;
  logic    passHit;
  logic    failHit;
  logic    stuckDisabled;   // Back from stage 3 to stage 1
  verdictT verdict;

  // ----------------------------------------
  // Pipeline stages
  // ----------------------------------------
  traceCapture traceCapture_inst (
    .clk, .pcFail, .retire, .retirePc,
    .disableStuck (stuckDisabled),
    .capValid, .capPc, .stuck
  );

  addressMatch addressMatch_inst (
    .clk, .pcFail, .capValid, .capPc,
    .stuckIn (stuck),
    .passPc, .failPc, .finishPc, .toHostPc, .failAltPc, .checkToHost,
    .passHit, .failHit
  );

  verdictControl verdictControl_inst (
    .clk, .pcFail, .passHit, .failHit, .setFail,
    .disableStuckReq (disableStuck),
    .verdict, .stuckDisabled, .coreHold
  );

  // One-hot verdict bits
  assign passed = verdict[0];
  assign failed = verdict[1];

endmodule

/* hw/pcMonitor/traceCapture.sv */
/*
  Trace capture, first stage of the PC monitor
  Registers the retired PC and counts repeats to flag a stuck core
*/
`timescale 1ns/10ps
`include "pcMonitorConsts.svh"

module traceCapture (
  input  logic         clk,
  input  logic         pcFail,        // Async reset
  input  logic         retire,        // One pulse per retired instruction
  input  tracePkg::pcT retirePc,
  input  logic         disableStuck,  // Sticky, from the verdict stage
  output logic         capValid,
  output tracePkg::pcT capPc,
  output logic         stuck
);
  import tracePkg::*;

  pcT         lastPc;       // Last retired PC
  stuckCountT stuckCount;   // Consecutive repeats of lastPc
  logic       samePc;
  logic       atLimit;

  assign samePc  = (retirePc == lastPc);
  assign atLimit = (stuckCount == stuckCountT'(`STUCK_LIMIT));

  // ----------------------------------------
  // Trace register and repeat counter
  // ----------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      capValid   <= 1'b0;
      lastPc     <= '0;
      stuckCount <= '0;
    end else begin
      capValid <= retire;
      if (retire) begin
        lastPc <= retirePc;
        if (!samePc) begin
          stuckCount <= '0;                     // New PC restarts the count
        end else if (!atLimit) begin
          stuckCount <= stuckCount + 1'b1;      // Saturate at the limit
        end
      end
    end
  end

  // Captured PC is the last retired one
  assign capPc = lastPc;

  // Stuck only while the checker is enabled
  assign stuck = atLimit && !disableStuck;

endmodule

/* hw/pcMonitor/verdictControl.sv */
/*
  Verdict control, third stage of the PC monitor
  Latches the verdict, runs the sleep timer and drives the core hold
*/
`timescale 1ns/10ps
`include "pcMonitorConsts.svh"

module verdictControl (
  input  logic                clk,
  input  logic                pcFail,           // Async reset
  input  logic                passHit,
  input  logic                failHit,
  input  logic                setFail,          // Forces a fail verdict
  input  logic                disableStuckReq,  // Strobe
  output verdictPkg::verdictT verdict,
  output logic                stuckDisabled,
  output logic                coreHold
);
  import verdictPkg::*;

  sleepCountT sleepCount;
  logic       sleeping;    // Timer running
  logic       anyHit;
  logic       firstHit;

  assign anyHit   = passHit || failHit;
  assign firstHit = anyHit && (verdict == verdictNone);

  // ----------------------------------------
  // Verdict latch
  // ----------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      verdict <= verdictNone;
    end else if (setFail) begin
      verdict <= verdictFail;              // Clears pass as well
    end else if (firstHit) begin
      verdict <= failHit ? verdictFail : verdictPass;   // Fail wins
    end
  end

  // Sticky disable of the stuck checker
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      stuckDisabled <= 1'b0;
    end else if (disableStuckReq) begin
      stuckDisabled <= 1'b1;
    end
  end

  // ----------------------------------------
  // Sleep timer and core hold
  // ----------------------------------------
  always_ff @(posedge clk or posedge pcFail) begin
    if (pcFail) begin
      sleeping   <= 1'b0;
      sleepCount <= '0;
      coreHold   <= 1'b0;
    end else if (firstHit) begin
      sleeping   <= 1'b1;
      sleepCount <= '0;
    end else if (sleeping) begin
      if (sleepCount == sleepLast) begin
        sleeping <= 1'b0;
        coreHold <= !stuckDisabled;   // Parked core stays held
      end else begin
        sleepCount <= sleepCount + 1'b1;
      end
    end
  end

endmodule

/* pcMonitor.f */
+incdir+common
common/tracePkg.sv
common/verdictPkg.sv
hw/pcMonitor/traceCapture.sv
hw/pcMonitor/addressMatch.sv
hw/pcMonitor/verdictControl.sv
hw/pcMonitor/pcMonitor.sv
tests/tbPcMonitor.sv

/* tests/tbPcMonitor.sv */
/*
  Testbench for the PC monitor
  Expected outputs follow the pipeline timing, assertions compare every cycle
*/
`timescale 1ns/10ps
`include "pcMonitorConsts.svh"

module tbPcMonitor;
  import tracePkg::*;

  // Every target has bit 29 set, random PCs have it clear
  localparam pcT passTarget    = 64'h2000_1000;
  localparam pcT failTarget    = 64'h2000_2000;
  localparam pcT finishTarget  = 64'h2000_3000;
  localparam pcT toHostTarget  = 64'h2000_4000;
  localparam pcT failAltTarget = 64'h2000_5000;
  localparam pcT targetBit     = 64'h2000_0000;
  localparam int cycleLimit = 2 * (`STUCK_LIMIT + 60) + 8 * (`SLEEP_DELAY + 40) + 200;

  logic clk;
  logic pcFail;
  logic retire;
  pcT   retirePc;
  pcT   passPc;
  pcT   failPc;
  pcT   finishPc;
  pcT   toHostPc;
  pcT   failAltPc;
  logic checkToHost;
  logic setFail;
  logic disableStuck;
  logic passed;
  logic failed;
  logic stuck;
  logic coreHold;

  logic expPassed;   // Expected outputs, moved at the DUT's edges
  logic expFailed;
  logic expStuck;
  logic expHold;
  int errCount = 0;
  int errStart = 0;
  int testCount = 0;
  int failCount = 0;
  int cycles = 0;
  logic [31:0] rngState = 32'h50641983;

  pcMonitor pcMonitor_inst (
    .clk, .pcFail, .retire, .retirePc,
    .passPc, .failPc, .finishPc, .toHostPc, .failAltPc,
    .checkToHost, .setFail, .disableStuck,
    .passed, .failed, .stuck, .coreHold
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("Timeout: no end of the run after %0d cycles", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic reportValue(input string name, input logic got, input logic want);
    $display("ERR %s got %h expected %h at %0t", name, got, want, $time);
    errCount++;
  endtask

  // ----------------------------------------
  // Output checks
  // ----------------------------------------
  checkPassed: assert property (@(posedge clk) disable iff (pcFail) passed == expPassed)
    else reportValue("passed", $sampled(passed), $sampled(expPassed));
  checkFailed: assert property (@(posedge clk) disable iff (pcFail) failed == expFailed)
    else reportValue("failed", $sampled(failed), $sampled(expFailed));
  checkStuck: assert property (@(posedge clk) disable iff (pcFail) stuck == expStuck)
    else reportValue("stuck", $sampled(stuck), $sampled(expStuck));
  checkHold: assert property (@(posedge clk) disable iff (pcFail) coreHold == expHold)
    else reportValue("coreHold", $sampled(coreHold), $sampled(expHold));

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic pcT randomPc();
    logic [31:0] hi;
    rngState = xorshift(rngState);
    hi = rngState;
    rngState = xorshift(rngState);
    return ({hi, rngState} & ~targetBit) | 64'h4;   // Never a target, never zero
  endfunction

  task automatic resetDut();
    pcFail    <= 1'b1;
    expPassed <= 1'b0;
    expFailed <= 1'b0;
    expStuck  <= 1'b0;
    expHold   <= 1'b0;
    repeat (5) @(posedge clk);
    pcFail <= 1'b0;
    @(posedge clk);
  endtask

  task automatic startTest();
    resetDut();
    errStart = errCount;
  endtask

  task automatic endTest(input string name);
    testCount++;
    if (errCount != errStart) failCount++;
    $display("Test %0d %s: %s", testCount, name, (errCount == errStart) ? "ok" : "errors");
  endtask

  // Returns on the edge that samples the retire
  task automatic retireOne(input pcT pc);
    retire   <= 1'b1;
    retirePc <= pc;
    @(posedge clk);
    retire   <= 1'b0;
    retirePc <= randomPc();
  endtask

  // First retire loads the PC, the rest are repeats
  task automatic repeatPc(input pcT pc);
    for (int i = 0; i <= `STUCK_LIMIT; i++) begin
      retire   <= 1'b1;
      retirePc <= pc;
      @(posedge clk);
    end
    retire <= 1'b0;
  endtask

  // Verdict 2 edges after the sampling edge, hold SLEEP_DELAY edges later
  task automatic awaitVerdict(input logic isFail, input logic holdOn);
    repeat (2) @(posedge clk);
    if (isFail) expFailed <= 1'b1;
    else expPassed <= 1'b1;
    repeat (`SLEEP_DELAY) @(posedge clk);
    if (holdOn) expHold <= 1'b1;
    repeat (3) @(posedge clk);
  endtask

  initial begin
    clk = 1'b0;
    retire <= 1'b0;
    retirePc <= '0;
    passPc <= passTarget;
    failPc <= failTarget;
    finishPc <= finishTarget;
    toHostPc <= toHostTarget;
    failAltPc <= failAltTarget;
    checkToHost <= 1'b0;
    setFail <= 1'b0;
    disableStuck <= 1'b0;
    startTest();
    retireOne(passTarget);
    awaitVerdict(1'b0, 1'b1);
    endTest("pass target");
    startTest();
    retireOne(failTarget);
    awaitVerdict(1'b1, 1'b1);
    endTest("fail target");
    startTest();
    failAltPc <= '0;          // Zero alt target is off
    retireOne(64'h0);
    repeat (8) @(posedge clk);
    failAltPc <= failAltTarget;
    endTest("zero alt fail target");
    startTest();
    retireOne(toHostTarget);  // checkToHost still low
    repeat (8) @(posedge clk);
    checkToHost <= 1'b1;
    retireOne(toHostTarget);
    awaitVerdict(1'b0, 1'b1);
    checkToHost <= 1'b0;
    endTest("to-host target");
    startTest();
    repeatPc(randomPc());
    expStuck <= 1'b1;
    awaitVerdict(1'b1, 1'b1);
    endTest("stuck core");
    startTest();
    disableStuck <= 1'b1;
    @(posedge clk);
    disableStuck <= 1'b0;
    repeatPc(randomPc());
    repeat (8) @(posedge clk);
    retireOne(passTarget);
    awaitVerdict(1'b0, 1'b0);  // Hold stays off
    endTest("stuck checker disabled");
    startTest();
    setFail <= 1'b1;
    @(posedge clk);
    setFail <= 1'b0;
    expFailed <= 1'b1;
    repeat (`SLEEP_DELAY + 5) @(posedge clk);
    endTest("forced fail");
    startTest();
    retireOne(passTarget);
    awaitVerdict(1'b0, 1'b1);
    retireOne(failTarget);     // Verdict already taken
    repeat (6) @(posedge clk);
    resetDut();
    repeat (3) @(posedge clk);
    endTest("first verdict kept");
    $display("Tests %0d, failing %0d, errors %0d", testCount, failCount, errCount);
    if (errCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
